//--- hdl/bp_config_pkg.sv
/*
 * table sizes and address field positions for the branch predictor.
 * entry counts must be powers of two; index widths are derived from them.
 * instructions are assumed 4-byte aligned, so pc bits 1:0 are never used.
 */
package bp_config_pkg;

    localparam int ADDR_W      = 32; // rv32 instruction address
    localparam int INSTR_BYTES = 4;  // call return address offset

    localparam int RAS_DEPTH   = 4;
    localparam int RAS_PTR_W   = $clog2(RAS_DEPTH);
    localparam int RAS_COUNT_W = $clog2(RAS_DEPTH + 1); // 0..RAS_DEPTH

    localparam int PHT_ENTRIES = 64;
    localparam int PHT_IDX_LSB = 2;  // skip byte offset
    localparam int PHT_IDX_W   = $clog2(PHT_ENTRIES);
    localparam int COUNTER_W   = 2;

    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_LSB = 2;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_W; // tag is everything above index
    localparam int BTB_TAG_W   = ADDR_W - BTB_TAG_LSB;

    localparam int KIND_W      = 3;  // predecode kind field

endpackage

//--- hdl/bp_types_pkg.sv
/*
 * shared types for the predictor: vectors, kind codes and packed structs.
 * kind is predecode data from fetch, so it is a plain vector, not an enum.
 * counter values 2 and 3 mean taken.
 */
package bp_types_pkg;

    typedef logic [bp_config_pkg::ADDR_W-1:0]      addr_t;
    typedef logic [bp_config_pkg::RAS_PTR_W-1:0]   ras_ptr_t;
    typedef logic [bp_config_pkg::RAS_COUNT_W-1:0] ras_count_t;
    typedef logic [bp_config_pkg::PHT_IDX_W-1:0]   pht_idx_t;
    typedef logic [bp_config_pkg::COUNTER_W-1:0]   counter_t;
    typedef logic [bp_config_pkg::BTB_IDX_W-1:0]   btb_idx_t;
    typedef logic [bp_config_pkg::BTB_TAG_W-1:0]   btb_tag_t;
    typedef logic [bp_config_pkg::KIND_W-1:0]      br_kind_t;

    // predecode kind codes
    localparam br_kind_t KIND_NONE = 3'd0;
    localparam br_kind_t KIND_COND = 3'd1;
    localparam br_kind_t KIND_JUMP = 3'd2;
    localparam br_kind_t KIND_CALL = 3'd3;
    localparam br_kind_t KIND_RET  = 3'd4;

    // saturating counter points
    localparam counter_t CTR_MIN     = 2'd0;
    localparam counter_t CTR_WEAK_NT = 2'd1; // reset value
    localparam counter_t CTR_WEAK_T  = 2'd2; // taken threshold
    localparam counter_t CTR_MAX     = 2'd3;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        br_kind_t kind;
    } fetch_req_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t target; // zero when not taken
    } prediction_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        br_kind_t kind;
        logic     taken;
        addr_t    target;
    } resolve_t;

    typedef struct packed {
        logic  hit;
        addr_t target;
    } btb_lookup_t;

endpackage

//--- hdl/branch_predictor.sv
/*
 * branch prediction front end, one request per cycle, no back-pressure.
 * prediction arrives the cycle after the request is sampled.
 */
module branch_predictor (
    input  logic                      clock,
    input  logic                      reset,
    input  bp_types_pkg::fetch_req_t  req,
    input  bp_types_pkg::resolve_t    resolve,
    output bp_types_pkg::prediction_t pred
);

    logic                      ras_push;
    logic                      ras_pop;
    bp_types_pkg::addr_t       ras_push_addr;
    bp_types_pkg::addr_t       ras_top;
    bp_types_pkg::ras_count_t  ras_count;
    bp_types_pkg::addr_t       lookup_addr;
    bp_types_pkg::pht_idx_t    pht_idx;
    bp_types_pkg::counter_t    pht_counter;
    bp_types_pkg::btb_lookup_t btb_lookup;
    logic                      pht_wr_en;
    logic                      btb_wr_en;

    predict_control ctrl (
        .clock, .reset, .req, .resolve, .pred,
        .ras_push, .ras_pop, .ras_push_addr, .ras_top, .ras_count,
        .lookup_addr, .pht_idx, .pht_counter, .btb_lookup,
        .pht_wr_en, .btb_wr_en
    );

    return_stack ras (
        .clock, .reset,
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (ras_push_addr),
        .top       (ras_top),
        .count     (ras_count)
    );

    pattern_history pht (
        .clock, .reset,
        .rd_idx     (pht_idx),
        .rd_counter (pht_counter),
        .wr_en      (pht_wr_en),
        .wr_idx     (resolve.pc[bp_config_pkg::PHT_IDX_LSB +: bp_config_pkg::PHT_IDX_W]),
        .wr_taken   (resolve.taken)
    );

    target_buffer btb (
        .clock, .reset,
        .rd_addr   (lookup_addr),
        .lookup    (btb_lookup),
        .wr_en     (btb_wr_en),
        .wr_addr   (resolve.pc),
        .wr_target (resolve.target)
    );

endmodule

//--- hdl/pattern_history.sv
/*
 * 2-bit saturating counter table for conditional branches.
 * read is registered: one cycle from rd_idx to rd_counter.
 * a write and a read of the same index on one edge return the old value.
 * all counters reset to weakly not-taken.
 */
module pattern_history (
    input  logic                   clock,
    input  logic                   reset,
    input  bp_types_pkg::pht_idx_t rd_idx,
    output bp_types_pkg::counter_t rd_counter,
    input  logic                   wr_en,
    input  bp_types_pkg::pht_idx_t wr_idx,
    input  logic                   wr_taken
);

    bp_types_pkg::counter_t counters [bp_config_pkg::PHT_ENTRIES];

    // saturating step, up on taken and down otherwise
    function automatic bp_types_pkg::counter_t sat_update(
        input bp_types_pkg::counter_t cur,
        input logic                   up
    );
        bp_types_pkg::counter_t nxt;
        nxt = cur;
        if (up && cur != bp_types_pkg::CTR_MAX) begin
            nxt = cur + 1'b1;
        end else if (!up && cur != bp_types_pkg::CTR_MIN) begin
            nxt = cur - 1'b1;
        end
        return nxt;
    endfunction

    // counter array, cleared to weak nt on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bp_config_pkg::PHT_ENTRIES; i++) begin
                counters[i] <= bp_types_pkg::CTR_WEAK_NT;
            end
        end else if (wr_en) begin
            counters[wr_idx] <= sat_update(counters[wr_idx], wr_taken);
        end
    end

    always_ff @(posedge clock) begin
        rd_counter <= counters[rd_idx]; // lines up with prediction stage
    end

endmodule

//--- hdl/predict_control.sv
/*
 * request decode, stack strobes and prediction forming.
 * request stage drives the tables and the stack at edge N;
 * pred is formed next cycle from registered kind, return target and table reads.
 * resolves train the counters (conditional only) and the btb (taken, not return).
 */
module predict_control (
    input  logic                       clock,
    input  logic                       reset,
    input  bp_types_pkg::fetch_req_t   req,
    input  bp_types_pkg::resolve_t     resolve,
    output bp_types_pkg::prediction_t  pred,
    output logic                       ras_push,
    output logic                       ras_pop,
    output bp_types_pkg::addr_t        ras_push_addr,
    input  bp_types_pkg::addr_t        ras_top,
    input  bp_types_pkg::ras_count_t   ras_count,
    output bp_types_pkg::addr_t        lookup_addr,
    output bp_types_pkg::pht_idx_t     pht_idx,
    input  bp_types_pkg::counter_t     pht_counter,
    input  bp_types_pkg::btb_lookup_t  btb_lookup,
    output logic                       pht_wr_en,
    output logic                       btb_wr_en
);

    logic                   valid_q;
    bp_types_pkg::br_kind_t kind_q;
    logic                   ret_ok_q;     // stack was non-empty at request
    bp_types_pkg::addr_t    ret_target_q;
    logic                   taken;
    bp_types_pkg::addr_t    target;

    // request stage
    assign ras_push      = req.valid && (req.kind == bp_types_pkg::KIND_CALL);
    assign ras_pop       = req.valid && (req.kind == bp_types_pkg::KIND_RET);
    assign ras_push_addr = req.pc + bp_types_pkg::addr_t'(bp_config_pkg::INSTR_BYTES);
    assign lookup_addr   = req.pc;
    assign pht_idx       = req.pc[bp_config_pkg::PHT_IDX_LSB +: bp_config_pkg::PHT_IDX_W];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // payload of the in-flight request
    always_ff @(posedge clock) begin
        kind_q       <= req.kind;
        ret_ok_q     <= (ras_count != '0); // empty test lives here only
        ret_target_q <= ras_top;           // pop happens on this same edge
    end

    // prediction stage
    always_comb begin
        taken  = 1'b0;
        target = btb_lookup.target;
        case (kind_q)
            bp_types_pkg::KIND_NONE: taken = 1'b0;
            bp_types_pkg::KIND_COND: begin
                taken = btb_lookup.hit && (pht_counter >= bp_types_pkg::CTR_WEAK_T);
            end
            bp_types_pkg::KIND_JUMP,
            bp_types_pkg::KIND_CALL: taken = btb_lookup.hit;
            bp_types_pkg::KIND_RET: begin
                taken  = ret_ok_q;
                target = ret_target_q;
            end
            default: taken = 1'b0; // unused codes act as none
        endcase
    end

    assign pred.valid  = valid_q;
    assign pred.taken  = valid_q && taken;
    assign pred.target = pred.taken ? target : '0;

    // training strobes, pc and outcome go straight to the tables
    assign pht_wr_en = resolve.valid && (resolve.kind == bp_types_pkg::KIND_COND);
    assign btb_wr_en = resolve.valid && resolve.taken &&
                       (resolve.kind != bp_types_pkg::KIND_RET);

endmodule

//--- hdl/return_stack.sv
/*
 * return address stack, circular array with top pointer and occupancy.
 * push on full and pop on empty are silently dropped; push wins over pop.
 * no repair after mispredict: the stack follows fetch order only.
 * top is a combinational read of the current entry, undefined when empty.
 */
module return_stack (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    push,
    input  logic                    pop,
    input  bp_types_pkg::addr_t     push_addr,
    output bp_types_pkg::addr_t     top,
    output bp_types_pkg::ras_count_t count
);

    bp_types_pkg::addr_t    stack [bp_config_pkg::RAS_DEPTH]; // payload, no reset
    bp_types_pkg::ras_ptr_t tos;      // points at current top entry
    bp_types_pkg::ras_ptr_t tos_up;   // slot for next push, wraps
    logic                   full;
    logic                   empty;

    assign tos_up = tos + 1'b1;
    assign full   = (count == bp_types_pkg::ras_count_t'(bp_config_pkg::RAS_DEPTH));
    assign empty  = (count == '0);
    assign top    = stack[tos];

    // pointer and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            tos   <= '0;
            count <= '0;
        end else if (push) begin
            if (!full) begin
                tos   <= tos_up;
                count <= count + 1'b1;
            end
        end else if (pop && !empty) begin
            tos   <= tos - 1'b1; // wraps back, old entry left stale
            count <= count - 1'b1;
        end
    end

    // entry write, same guard as the pointer
    always_ff @(posedge clock) begin
        if (push && !full) begin
            stack[tos_up] <= push_addr;
        end
    end

endmodule

//--- hdl/target_buffer.sv
/*
 * direct-mapped tagged branch target buffer.
 * index is addr[5:2], tag is the upper 26 bits; a write overwrites the entry.
 * lookup is registered, one cycle from rd_addr to lookup.
 * target on a miss is don't-care, the control zeroes it.
 */
module target_buffer (
    input  logic                      clock,
    input  logic                      reset,
    input  bp_types_pkg::addr_t       rd_addr,
    output bp_types_pkg::btb_lookup_t lookup,
    input  logic                      wr_en,
    input  bp_types_pkg::addr_t       wr_addr,
    input  bp_types_pkg::addr_t       wr_target
);

    logic                [bp_config_pkg::BTB_ENTRIES-1:0] valid;
    bp_types_pkg::btb_tag_t tags    [bp_config_pkg::BTB_ENTRIES];
    bp_types_pkg::addr_t    targets [bp_config_pkg::BTB_ENTRIES];

    bp_types_pkg::btb_idx_t rd_idx;
    bp_types_pkg::btb_tag_t rd_tag;
    bp_types_pkg::btb_idx_t wr_idx;
    bp_types_pkg::btb_tag_t wr_tag;

    // address split, same for both ports
    assign rd_idx = rd_addr[bp_config_pkg::BTB_IDX_LSB +: bp_config_pkg::BTB_IDX_W];
    assign rd_tag = rd_addr[bp_config_pkg::BTB_TAG_LSB +: bp_config_pkg::BTB_TAG_W];
    assign wr_idx = wr_addr[bp_config_pkg::BTB_IDX_LSB +: bp_config_pkg::BTB_IDX_W];
    assign wr_tag = wr_addr[bp_config_pkg::BTB_TAG_LSB +: bp_config_pkg::BTB_TAG_W];

    // valid bits are the only state that needs clearing
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            tags[wr_idx]    <= wr_tag;
            targets[wr_idx] <= wr_target;
        end
    end

    // registered lookup, sees writes from earlier edges only
    always_ff @(posedge clock) begin
        lookup.hit    <= valid[rd_idx] && (tags[rd_idx] == rd_tag);
        lookup.target <= targets[rd_idx];
    end

endmodule

//--- list.f
hdl/bp_config_pkg.sv
hdl/bp_types_pkg.sv
hdl/return_stack.sv
hdl/pattern_history.sv
hdl/target_buffer.sv
hdl/predict_control.sv
hdl/branch_predictor.sv
verification/clock_gen.sv
verification/prediction_monitor.sv
verification/bp_checker.sv
verification/tb_branch_predictor.sv

//--- verification/bp_checker.sv
/*
 * assertions bound into branch_predictor.
 * ras_count is the return_stack count output as seen by the top level.
 * covers stack bound, one-cycle request to prediction timing, quiet after reset.
 */
module bp_checker (
    input logic                      clock,
    input logic                      reset,
    input bp_types_pkg::fetch_req_t  req,
    input bp_types_pkg::prediction_t pred,
    input bp_types_pkg::ras_count_t  ras_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0; // read by the testbench top

    stack_bound: assert property (@(posedge clock) disable iff (reset)
        ras_count <= bp_types_pkg::ras_count_t'(bp_config_pkg::RAS_DEPTH))
        else begin
            failures++;
            $error("return stack count went above its depth");
        end

    // exactly one cycle, both directions
    pred_after_req: assert property (@(posedge clock) disable iff (reset)
        req.valid |=> pred.valid)
        else begin
            failures++;
            $error("request was not answered on the next cycle");
        end
    no_stray_pred: assert property (@(posedge clock) disable iff (reset)
        !req.valid |=> !pred.valid)
        else begin
            failures++;
            $error("prediction appeared without a request");
        end

    quiet_after_reset: assert property (@(posedge clock) reset |=> !pred.valid)
        else begin
            failures++;
            $error("prediction valid in the cycle after reset");
        end

endmodule

bind branch_predictor bp_checker chk (.clock, .reset, .req, .pred, .ras_count);

//--- verification/bp_trace.txt
# name req_valid req_pc req_kind res_valid res_pc res_kind res_taken res_target exp_taken exp_target
# all hex; kind 0 none 1 cond 2 jump 3 call 4 ret; exp_* is the answer to this line's request
reset_cond  1 00001000 1 0 00000000 0 0 00000000 0 00000000
reset_jump  1 00001010 2 0 00000000 0 0 00000000 0 00000000
reset_call  1 00001020 3 0 00000000 0 0 00000000 0 00000000
pair_call_a 1 00002000 3 0 00000000 0 0 00000000 0 00000000
pair_call_b 1 00002100 3 0 00000000 0 0 00000000 0 00000000
pair_ret_b  1 00002200 4 0 00000000 0 0 00000000 1 00002104
pair_ret_a  1 00002204 4 0 00000000 0 0 00000000 1 00002004
pair_ret_rc 1 00002208 4 0 00000000 0 0 00000000 1 00001024
pair_ret_e  1 0000220c 4 0 00000000 0 0 00000000 0 00000000
bound_call1 1 00003000 3 0 00000000 0 0 00000000 0 00000000
bound_call2 1 00003010 3 0 00000000 0 0 00000000 0 00000000
bound_call3 1 00003020 3 0 00000000 0 0 00000000 0 00000000
bound_call4 1 00003030 3 0 00000000 0 0 00000000 0 00000000
bound_call5 1 00003040 3 0 00000000 0 0 00000000 0 00000000
bound_ret4  1 00003100 4 0 00000000 0 0 00000000 1 00003034
bound_ret3  1 00003104 4 0 00000000 0 0 00000000 1 00003024
bound_ret2  1 00003108 4 0 00000000 0 0 00000000 1 00003014
bound_ret1  1 0000310c 4 0 00000000 0 0 00000000 1 00003004
bound_ret0  1 00003110 4 0 00000000 0 0 00000000 0 00000000
ctr_learn   0 00000000 0 1 00004000 1 1 00004400 0 00000000
ctr_up      0 00000000 0 1 00004000 1 1 00004400 0 00000000
ctr_taken   1 00004000 1 0 00000000 0 0 00000000 1 00004400
ctr_down1   0 00000000 0 1 00004000 1 0 00000000 0 00000000
ctr_down2   0 00000000 0 1 00004000 1 0 00000000 0 00000000
ctr_nt      1 00004000 1 0 00000000 0 0 00000000 0 00000000
alias_learn 0 00000000 0 1 00005008 2 1 00005800 0 00000000
alias_miss  1 00006008 2 0 00000000 0 0 00000000 0 00000000
alias_hit   1 00005008 2 0 00000000 0 0 00000000 1 00005800
b2b_learn   1 00005008 2 1 00005008 2 1 00005900 1 00005800
b2b_call    1 00007000 3 0 00000000 0 0 00000000 0 00000000
b2b_ret     1 00007100 4 0 00000000 0 0 00000000 1 00007004
b2b_jump    1 00005008 2 0 00000000 0 0 00000000 1 00005900
b2b_none    1 00007200 0 0 00000000 0 0 00000000 0 00000000

//--- verification/clock_gen.sv
/*
 * 10 ns clock and a synchronous active-high reset held for 5 rising edges.
 */
module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock; // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0; // released on the edge, like any other input
    end

endmodule

//--- verification/prediction_monitor.sv
/*
 * compares each prediction with the expected value captured with its request.
 * only one request is ever in flight, so one pending entry is enough.
 * expected values arrive on the same edge as the request they belong to.
 */
module prediction_monitor (
    input  logic                      clock,
    input  logic                      reset,
    input  bp_types_pkg::fetch_req_t  req,
    input  bp_types_pkg::prediction_t pred,
    input  logic                      exp_taken,
    input  bp_types_pkg::addr_t       exp_target,
    input  logic [127:0]              exp_name,
    output int                        error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                pending;     // request sampled last edge
    logic                pend_taken;
    bp_types_pkg::addr_t pend_target;
    logic [127:0]        pend_name;
    int                  errors = 0;

    assign error_count = errors;

    always @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            if (pred.valid && !pending) begin
                $display("prediction at %0t ns arrived with no request pending", $time);
                errors++;
            end else if (pending && !pred.valid) begin
                $display("request of test %0s got no prediction", pend_name);
                errors++;
            end else if (pending) begin
                if (pred.taken !== pend_taken || pred.target !== pend_target) begin
                    $display("[ERROR] %0s: expected taken=%0b target=%h, actual taken=%0b target=%h",
                             pend_name, pend_taken, pend_target, pred.taken, pred.target);
                    errors++;
                end
            end
            pending     <= req.valid;   // answer due next edge
            pend_taken  <= exp_taken;
            pend_target <= exp_target;
            pend_name   <= exp_name;
        end
    end

endmodule

//--- verification/tb_branch_predictor.sv
/*
 * testbench for branch_predictor, stimulus and expected values from a trace.
 * run from the project root so verification/bp_trace.txt resolves.
 * one trace line per clock after reset; a line's expected values belong to its request.
 */
module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 100ps;

    logic                      clock;
    logic                      reset;
    bp_types_pkg::fetch_req_t  req;
    bp_types_pkg::resolve_t    resolve;
    bp_types_pkg::prediction_t pred;
    logic                      exp_taken;
    bp_types_pkg::addr_t       exp_target;
    logic [127:0]              exp_name;   // up to 16 chars
    int                        error_count;
    int                        trace_errors = 0;
    logic                      loaded = 1'b0;

    // trace contents, one entry per data line
    logic [127:0]              names [$];
    bp_types_pkg::fetch_req_t  reqs [$];
    bp_types_pkg::resolve_t    resolves [$];
    logic                      takens [$];
    bp_types_pkg::addr_t       targets [$];

    clock_gen clk_gen (.clock, .reset);

    branch_predictor uut (.clock, .reset, .req, .resolve, .pred);

    prediction_monitor monitor (
        .clock, .reset, .req, .pred,
        .exp_taken, .exp_target, .exp_name, .error_count
    );

    task automatic load_trace();
        int                       fd;
        int                       n;
        string                    line;
        logic [127:0]             name;
        logic [31:0]              f [10];
        bp_types_pkg::fetch_req_t r;
        bp_types_pkg::resolve_t   s;
        fd = $fopen("verification/bp_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin   // skip blanks and comments
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name,
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (n == 11) begin
                        r.valid  = f[0][0];
                        r.pc     = f[1];
                        r.kind   = f[2][2:0];
                        s.valid  = f[3][0];
                        s.pc     = f[4];
                        s.kind   = f[5][2:0];
                        s.taken  = f[6][0];
                        s.target = f[7];
                        names.push_back(name);
                        reqs.push_back(r);
                        resolves.push_back(s);
                        takens.push_back(f[8][0]);
                        targets.push_back(f[9]);
                    end else begin
                        $display("trace line could not be parsed: %s", line);
                        trace_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        req        = '0;    // idle until reset is gone
        resolve    = '0;
        exp_taken  = 1'b0;
        exp_target = '0;
        exp_name   = '0;
        void'($urandom(32'h063761cf));
        load_trace();
        if (reqs.size() == 0) begin
            $display("trace file is missing or holds no usable lines");
            $display("Finished with errors");
            $finish;
        end else begin
            loaded = 1'b1;
            @(posedge clock);
            while (reset) @(posedge clock);
            foreach (reqs[i]) begin
                req        <= reqs[i];
                resolve    <= resolves[i];
                exp_taken  <= takens[i];
                exp_target <= targets[i];
                exp_name   <= names[i];
                @(posedge clock);
            end
            req     <= '0;
            resolve <= '0;
            repeat (2) @(posedge clock); // last answer is one cycle behind
            #1;
            $display("prediction errors: %0d, trace errors: %0d, assertion failures: %0d",
                     error_count, trace_errors, uut.chk.failures);
            if (error_count == 0 && trace_errors == 0 && uut.chk.failures == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    // watchdog, sized from the trace length
    initial begin
        wait (loaded);
        #((reqs.size() + 20) * 10);
        $display("timeout: run did not finish within %0d clock cycles", reqs.size() + 20);
        $display("Finished with errors");
        $finish;
    end

endmodule
